// File: sim/mixer_stimulus.dat
// host regs: ch0 start, ch0 len, ch1 start, ch1 len, ch2 start, ch2 len, ch3 start, ch3 len
0002 0003 0011 8002 0020 0004 0035 8001
// periods ch0..ch3
0028 0030 0038 0040
// ch1 rewrite: new start, new len
0018 0005
// mix cases: vol_l ch0..3, vol_r ch0..3, expected dac left, expected dac right
0014 000A 001E 0005 0028 0000 0000 0000 0075 00BE
007F 007F 0000 0000 0000 0000 0000 0000 00FF 0080
0000 0000 0000 0000 0000 0000 007F 007F 0080 0000
// dma memory 0x00-0x3F, 16 words per channel, samples 100, 60, -100, -50
6464 6464 6464 6464 6464 6464 6464 6464 6464 6464 6464 6464 6464 6464 6464 6464
3C3C 3C3C 3C3C 3C3C 3C3C 3C3C 3C3C 3C3C 3C3C 3C3C 3C3C 3C3C 3C3C 3C3C 3C3C 3C3C
9C9C 9C9C 9C9C 9C9C 9C9C 9C9C 9C9C 9C9C 9C9C 9C9C 9C9C 9C9C 9C9C 9C9C 9C9C 9C9C
CECE CECE CECE CECE CECE CECE CECE CECE CECE CECE CECE CECE CECE CECE CECE CECE
// end marker
A5A5

// File: sim.f
+incdir+include
design/mixer_pkg.sv
design/sample_load_if.sv
design/param_write_arbiter.sv
design/param_mem.sv
design/sample_fetch.sv
design/channel_player.sv
design/channel_mixer.sv
design/pdm_dac.sv
design/audio_mixer_top.sv
sim/tb_audio_mixer.sv

// File: Makefile
VERILATOR ?= verilator
FILELIST  ?= sim.f
TB_TOP    ?= tb_audio_mixer
RTL_TOP   ?= audio_mixer_top
BUILD_DIR ?= obj_dir
SIM_BIN   ?= sim_tb
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Verification passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR) -o $(SIM_BIN)
	$(BUILD_DIR)/$(SIM_BIN) | tee /dev/stderr | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: sim/tb_audio_mixer.sv
`default_nettype none
`timescale 1ns/1ps

`include "mixer_config.svh"

module tb_audio_mixer import mixer_pkg::*; ();

localparam int STIM_N      = 109;               // words in the stimulus file
localparam int PERIOD_BASE = 8;
localparam int REWRITE_IDX = 12;                // new ch1 start, then new ch1 length
localparam int MIX_BASE    = 14;                // 10 words per mix case
localparam int DMA_BASE    = 44;
localparam int MARKER_IDX  = 108;
localparam int MIX_CASES   = 3;
localparam int RESET_CYC   = 16;
localparam int SETTLE_CYC  = 24;                // several mixer rounds
localparam int LEVEL_CYC   = 256;
localparam int REQ_TOTAL   = 40 + 2 + 40 + 1 + 30;
localparam int REQ_MAX_CYC = 200;               // fetch plus a channel running dry
localparam int TIMEOUT_CYC = RESET_CYC + 8 * 4 + 8 + REQ_TOTAL * REQ_MAX_CYC
                           + (MIX_CASES + 1) * (SETTLE_CYC + LEVEL_CYC + 2) + 100;
localparam int ACT_NONE    = 0;
localparam int ACT_HOST    = 1;
localparam int ACT_RESTART = 2;

logic                                   clk;
logic                                   reset_i;
logic                                   audio_enable_i;
logic                                   reg_wr_i;
logic [`MIX_PARAM_AW-2:0]               reg_addr_i;
word_t                                  reg_data_i;
logic [`MIX_VOL_W*`MIX_NCHAN-1:0]       vol_l_i;
logic [`MIX_VOL_W*`MIX_NCHAN-1:0]       vol_r_i;
logic [`MIX_PERIOD_W*`MIX_NCHAN-1:0]    period_i;
logic [`MIX_NCHAN-1:0]                  restart_i;
logic [`MIX_NCHAN-1:0]                  reload_o;
logic                                   dma_vram_req_o;
logic                                   dma_tile_req_o;
word_t                                  dma_addr_o;
logic                                   dma_ack_i;
word_t                                  dma_word_i;
logic                                   pdm_l_o;
logic                                   pdm_r_o;

word_t  stim [STIM_N];
word_t  dma_mem [64];                           // DMA memory model
word_t  host_reg [2*`MIX_NCHAN];                // host view of {chan, len}
logic   need_reload [`MIX_NCHAN];               // reference model per channel
logic [`MIX_TILE_B-1:0] work_cnt [`MIX_NCHAN];
logic   cur_tile [`MIX_NCHAN];
word_t  next_addr [`MIX_NCHAN];
int     reload_reqs [`MIX_NCHAN];               // reload requests seen
int     reload_total [`MIX_NCHAN];              // reload_o pulses, monitor only
int     reload_mark [`MIX_NCHAN];
int     mismatch_cnt = 0;
int     other_cnt = 0;
int     cycle_cnt = 0;
int     before_cnt;

audio_mixer_top u_audio_mixer_top (
    .clk(clk), .reset_i(reset_i), .audio_enable_i(audio_enable_i),
    .reg_wr_i(reg_wr_i), .reg_addr_i(reg_addr_i), .reg_data_i(reg_data_i),
    .vol_l_i(vol_l_i), .vol_r_i(vol_r_i), .period_i(period_i), .restart_i(restart_i),
    .reload_o(reload_o),
    .dma_vram_req_o(dma_vram_req_o), .dma_tile_req_o(dma_tile_req_o),
    .dma_addr_o(dma_addr_o), .dma_ack_i(dma_ack_i), .dma_word_i(dma_word_i),
    .pdm_l_o(pdm_l_o), .pdm_r_o(pdm_r_o)
);

always #4 clk = ~clk;                           // 8 ns period

always @(negedge clk) begin
    for (int c = 0; c < `MIX_NCHAN; c++) begin
        if (reload_o[c]) begin
            reload_total[c]++;                  // pulse count per channel
        end
    end
end

always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYC) begin
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
        $display("Verification failed");
        $finish;
    end
end

task automatic check_value(input string name, input int exp_v, input int act_v);
    assert (exp_v == act_v) else begin
        mismatch_cnt++;
        $display("Mismatch %s: expected %0h, actual %0h", name, exp_v, act_v);
    end
endtask

task automatic check_level(input string name, input int exp_v, input int act_v);
    assert (act_v >= exp_v - 1 && act_v <= exp_v + 1) else begin   // pdm may be off by one
        mismatch_cnt++;
        $display("Mismatch %s: expected %0d, actual %0d", name, exp_v, act_v);
    end
endtask

task automatic host_write(input logic [`MIX_PARAM_AW-2:0] addr, input word_t data);
    @(negedge clk);
    reg_wr_i   = 1'b1;
    reg_addr_i = addr;
    reg_data_i = data;
    @(negedge clk);
    reg_wr_i = 1'b0;
    repeat (2) @(negedge clk);                  // host gap
endtask

// expected address, request lines and reload pulses of one request
task automatic model_request(input word_t addr, input logic vram, input logic tile);
    chan_t c;
    word_t exp_addr;
    int    exp_pulses;
    int    pulses;
    c = chan_t'(addr[5:4]);                     // each channel owns 16 words
    if (need_reload[c] || work_cnt[c] == '0) begin
        exp_addr       = host_reg[{c, 1'b0}];
        exp_pulses     = 1;
        work_cnt[c]    = host_reg[{c, 1'b1}][`MIX_TILE_B-1:0];
        cur_tile[c]    = host_reg[{c, 1'b1}][`MIX_TILE_B];
        need_reload[c] = 1'b0;
        reload_reqs[c]++;
    end else begin
        exp_addr    = next_addr[c];
        exp_pulses  = 0;
        work_cnt[c] = work_cnt[c] - 1'b1;
    end
    next_addr[c]   = exp_addr + 1'b1;
    pulses         = reload_total[c] - reload_mark[c];
    reload_mark[c] = reload_total[c];
    check_value($sformatf("ch%0d address", c), exp_addr, addr);
    check_value($sformatf("ch%0d tile select", c), cur_tile[c], tile);
    check_value($sformatf("ch%0d vram select", c), !cur_tile[c], vram);
    check_value($sformatf("ch%0d reload pulses", c), exp_pulses, pulses);
endtask

// wait for a request, optionally act while it is open, then ack
task automatic serve_request(input int action, input logic [`MIX_PARAM_AW-2:0] a_addr,
                             input word_t a_data, input logic [`MIX_NCHAN-1:0] a_mask);
    int delay;
    @(negedge clk);
    while (!(dma_vram_req_o || dma_tile_req_o)) begin
        @(negedge clk);
    end
    model_request(dma_addr_o, dma_vram_req_o, dma_tile_req_o);
    if (action == ACT_HOST) begin
        reg_wr_i           = 1'b1;              // fetch is idle in wait ack
        reg_addr_i         = a_addr;
        reg_data_i         = a_data;
        host_reg[a_addr]   = a_data;
        @(negedge clk);
        reg_wr_i = 1'b0;
    end else if (action == ACT_RESTART) begin
        restart_i = a_mask;
        for (int c = 0; c < `MIX_NCHAN; c++) begin
            if (a_mask[c]) begin
                need_reload[c] = 1'b1;
            end
        end
        @(negedge clk);
        restart_i = '0;
    end
    delay = $urandom % 6;
    repeat (delay) @(negedge clk);
    dma_ack_i  = 1'b1;
    dma_word_i = dma_mem[dma_addr_o[5:0]];
    @(negedge clk);
    dma_ack_i = 1'b0;
endtask

task automatic count_pulses(output int ones_l, output int ones_r);
    ones_l = 0;
    ones_r = 0;
    repeat (LEVEL_CYC) begin
        @(negedge clk);
        ones_l += pdm_l_o;
        ones_r += pdm_r_o;
    end
endtask

task automatic run_mix_case(input int idx);
    int base;
    int ones_l;
    int ones_r;
    base = MIX_BASE + idx * 10;
    @(negedge clk);
    for (int c = 0; c < `MIX_NCHAN; c++) begin
        vol_l_i[c*`MIX_VOL_W +: `MIX_VOL_W] = stim[base + c][`MIX_VOL_W-1:0];
        vol_r_i[c*`MIX_VOL_W +: `MIX_VOL_W] = stim[base + 4 + c][`MIX_VOL_W-1:0];
    end
    repeat (SETTLE_CYC) @(negedge clk);
    count_pulses(ones_l, ones_r);
    check_level($sformatf("mix case %0d left", idx), stim[base + 8], ones_l);
    check_level($sformatf("mix case %0d right", idx), stim[base + 9], ones_r);
endtask

initial begin
    int ones_l;
    int ones_r;
    void'($urandom(32'he651));                  // one seed for the ack delays
    clk            = 1'b0;
    reset_i        = 1'b1;
    audio_enable_i = 1'b0;
    reg_wr_i       = 1'b0;
    reg_addr_i     = '0;
    reg_data_i     = '0;
    vol_l_i        = '0;
    vol_r_i        = '0;
    period_i       = '0;
    restart_i      = '0;
    dma_ack_i      = 1'b0;
    dma_word_i     = '0;
    $readmemh("sim/mixer_stimulus.dat", stim);
    assert (stim[MARKER_IDX] == 16'hA5A5) else begin
        other_cnt++;
        $display("Stimulus file is missing or shorter than expected");
    end
    for (int i = 0; i < 64; i++) begin
        dma_mem[i] = stim[DMA_BASE + i];
    end
    for (int c = 0; c < `MIX_NCHAN; c++) begin
        period_i[c*`MIX_PERIOD_W +: `MIX_PERIOD_W] = stim[PERIOD_BASE + c][`MIX_PERIOD_W-1:0];
        need_reload[c] = 1'b1;                  // every channel starts with a reload
        work_cnt[c]    = '0;
        cur_tile[c]    = 1'b0;
        next_addr[c]   = '0;
        reload_reqs[c] = 0;
        reload_mark[c] = 0;
    end
    repeat (RESET_CYC) @(negedge clk);
    reset_i = 1'b0;
    for (int a = 0; a < 2*`MIX_NCHAN; a++) begin
        host_reg[a] = stim[a];
        host_write(a[`MIX_PARAM_AW-2:0], stim[a]);
    end
    @(negedge clk);
    audio_enable_i = 1'b1;

    // address sequence and length reload
    repeat (40) serve_request(ACT_NONE, '0, '0, '0);

    // rewrite ch1 start and length while fetches run
    before_cnt = reload_reqs[1];
    serve_request(ACT_HOST, 3'b010, stim[REWRITE_IDX], '0);
    serve_request(ACT_HOST, 3'b011, stim[REWRITE_IDX + 1], '0);
    repeat (40) serve_request(ACT_NONE, '0, '0, '0);
    assert (reload_reqs[1] > before_cnt) else begin
        other_cnt++;
        $display("Channel 1 never reloaded after its registers were rewritten");
    end

    // restart of ch2
    before_cnt = reload_reqs[2];
    serve_request(ACT_RESTART, '0, '0, 4'b0100);
    repeat (30) serve_request(ACT_NONE, '0, '0, '0);
    assert (reload_reqs[2] > before_cnt) else begin
        other_cnt++;
        $display("Channel 2 was not fetched again after its restart");
    end

    // static samples, a pending request holds the buffers dry
    for (int k = 0; k < MIX_CASES; k++) begin
        run_mix_case(k);
    end

    // disable gives silence and no requests
    @(negedge clk);
    audio_enable_i = 1'b0;
    repeat (SETTLE_CYC) @(negedge clk);
    ones_l = 0;
    ones_r = 0;
    repeat (LEVEL_CYC) begin
        @(negedge clk);
        assert (!dma_vram_req_o && !dma_tile_req_o) else begin
            other_cnt++;
            $display("DMA request raised while audio is disabled");
        end
        ones_l += pdm_l_o;
        ones_r += pdm_r_o;
    end
    check_level("disabled left", 8'h80, ones_l);
    check_level("disabled right", 8'h80, ones_r);

    $display("Checks done: %0d mismatches, %0d other errors", mismatch_cnt, other_cnt);
    if (mismatch_cnt == 0 && other_cnt == 0) begin
        $display("Verification passed");
    end else begin
        $display("Verification failed");
    end
    $finish;
end

endmodule

`default_nettype wire

// File: design/audio_mixer_top.sv
`default_nettype none
`timescale 1ns/1ps

`include "mixer_config.svh"

module audio_mixer_top import mixer_pkg::*; (
    input  wire logic                                   clk,
    input  wire logic                                   reset_i,
    input  wire logic                                   audio_enable_i,
    input  wire logic                                   reg_wr_i,
    input  wire logic [`MIX_PARAM_AW-2:0]               reg_addr_i,
    input  wire word_t                                  reg_data_i,
    input  wire logic [`MIX_VOL_W*`MIX_NCHAN-1:0]       vol_l_i,
    input  wire logic [`MIX_VOL_W*`MIX_NCHAN-1:0]       vol_r_i,
    input  wire logic [`MIX_PERIOD_W*`MIX_NCHAN-1:0]    period_i,
    input  wire logic [`MIX_NCHAN-1:0]                  restart_i,
    output logic [`MIX_NCHAN-1:0]                       reload_o,
    output logic                                        dma_vram_req_o,
    output logic                                        dma_tile_req_o,
    output word_t                                       dma_addr_o,
    input  wire logic                                   dma_ack_i,
    input  wire word_t                                  dma_word_i,
    output logic                                        pdm_l_o,
    output logic                                        pdm_r_o
);

logic                   mem_wr;                 // arbiter to param mem
param_addr_t            mem_wr_addr;
word_t                  mem_wr_data;
param_addr_t            rd_addr;                // fetch read port
word_t                  rd_data;
logic                   f_wr;                   // fetch write request
param_addr_t            f_wr_addr;
word_t                  f_wr_data;
sample_t                samples [`MIX_NCHAN];
logic [`MIX_DAC_W-1:0]  out_l;
logic [`MIX_DAC_W-1:0]  out_r;

sample_load_if u_load ();

param_write_arbiter u_arbiter (
    .clk(clk), .reset_i(reset_i),
    .host_wr_i(reg_wr_i), .host_addr_i(reg_addr_i), .host_data_i(reg_data_i),
    .fetch_wr_i(f_wr), .fetch_addr_i(f_wr_addr), .fetch_data_i(f_wr_data),
    .mem_wr_o(mem_wr), .mem_addr_o(mem_wr_addr), .mem_data_o(mem_wr_data)
);

param_mem u_param_mem (
    .clk(clk), .rd_addr_i(rd_addr), .rd_data_o(rd_data),
    .wr_i(mem_wr), .wr_addr_i(mem_wr_addr), .wr_data_i(mem_wr_data)
);

sample_fetch u_fetch (
    .clk(clk), .reset_i(reset_i), .enable_i(audio_enable_i), .restart_i(restart_i),
    .rd_addr_o(rd_addr), .rd_data_i(rd_data),
    .wr_o(f_wr), .wr_addr_o(f_wr_addr), .wr_data_o(f_wr_data),
    .reload_o(reload_o),
    .dma_vram_req_o(dma_vram_req_o), .dma_tile_req_o(dma_tile_req_o),
    .dma_addr_o(dma_addr_o), .dma_ack_i(dma_ack_i), .dma_word_i(dma_word_i),
    .ld(u_load.fetch)
);

channel_player u_player (
    .clk(clk), .reset_i(reset_i), .enable_i(audio_enable_i), .restart_i(restart_i),
    .period_i(period_i), .sample_o(samples), .ld(u_load.player)
);

channel_mixer u_mixer (
    .clk(clk), .reset_i(reset_i), .sample_i(samples),
    .vol_l_i(vol_l_i), .vol_r_i(vol_r_i), .out_l_o(out_l), .out_r_o(out_r)
);

pdm_dac #(.WIDTH(`MIX_DAC_W)) u_dac_l (
    .clk(clk), .reset_i(reset_i), .value_i(out_l), .pulse_o(pdm_l_o)
);

pdm_dac #(.WIDTH(`MIX_DAC_W)) u_dac_r (
    .clk(clk), .reset_i(reset_i), .value_i(out_r), .pulse_o(pdm_r_o)
);

endmodule

`default_nettype wire

// File: design/pdm_dac.sv
`default_nettype none
`timescale 1ns/1ps

module pdm_dac #(
    parameter int WIDTH = 8
) (
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire logic [WIDTH-1:0]   value_i,    // unsigned level
    output logic                    pulse_o     // density follows value_i
);

logic [WIDTH:0] acc;                            // carry bit is the pulse

always_ff @(posedge clk) begin
    if (reset_i) begin
        acc <= '0;
    end else begin
        acc <= {1'b0, acc[WIDTH-1:0]} + {1'b0, value_i};
    end
end

assign pulse_o = acc[WIDTH];

endmodule

`default_nettype wire

// File: design/channel_mixer.sv
`default_nettype none
`timescale 1ns/1ps

`include "mixer_config.svh"

module channel_mixer import mixer_pkg::*; (
    input  wire logic                               clk,
    input  wire logic                               reset_i,
    input  wire sample_t                            sample_i [`MIX_NCHAN],
    input  wire logic [`MIX_VOL_W*`MIX_NCHAN-1:0]   vol_l_i,
    input  wire logic [`MIX_VOL_W*`MIX_NCHAN-1:0]   vol_r_i,
    output logic [`MIX_DAC_W-1:0]                   out_l_o,    // unsigned, 0x80 is silence
    output logic [`MIX_DAC_W-1:0]                   out_r_o
);

logic [`MIX_CHAN_W:0]   mix_chan;               // extra step for clamp and output
chan_t                  cidx;
logic signed [15:0]     prod_l;
logic signed [15:0]     prod_r;
logic signed [15:0]     acc_l;
logic signed [15:0]     acc_r;

// upper accumulator bits, clamped and made unsigned
function automatic logic [`MIX_DAC_W-1:0] clamp_u(input logic signed [15:0] acc);
    logic signed [9:0] top;
    top = acc[15:6];
    if (top < -10'sd128) begin
        clamp_u = 8'h00;
    end else if (top > 10'sd127) begin
        clamp_u = 8'hFF;
    end else begin
        clamp_u = top[7:0] ^ 8'h80;             // flip sign bit
    end
endfunction

assign cidx   = chan_t'(mix_chan);
assign prod_l = sample_i[cidx] * $signed({1'b0, vol_l_i[cidx*`MIX_VOL_W +: `MIX_VOL_W]});
assign prod_r = sample_i[cidx] * $signed({1'b0, vol_r_i[cidx*`MIX_VOL_W +: `MIX_VOL_W]});

always_ff @(posedge clk) begin
    if (mix_chan == '0) begin
        acc_l <= prod_l;                        // first channel starts a new sum
        acc_r <= prod_r;
    end else if (mix_chan != `MIX_NCHAN) begin
        acc_l <= acc_l + prod_l;
        acc_r <= acc_r + prod_r;
    end
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        mix_chan <= '0;
        out_l_o  <= `MIX_DAC_RST;
        out_r_o  <= `MIX_DAC_RST;
    end else if (mix_chan == `MIX_NCHAN) begin
        mix_chan <= '0;
        out_l_o  <= clamp_u(acc_l);             // once per round
        out_r_o  <= clamp_u(acc_r);
    end else begin
        mix_chan <= mix_chan + 1'b1;
    end
end

endmodule

`default_nettype wire

// File: design/channel_player.sv
`default_nettype none
`timescale 1ns/1ps

`include "mixer_config.svh"

module channel_player import mixer_pkg::*; (
    input  wire logic                                   clk,
    input  wire logic                                   reset_i,
    input  wire logic                                   enable_i,
    input  wire logic [`MIX_NCHAN-1:0]                  restart_i,
    input  wire logic [`MIX_PERIOD_W*`MIX_NCHAN-1:0]    period_i,
    output sample_t                                     sample_o [`MIX_NCHAN],
    sample_load_if.player                               ld
);

word_t                  buf_q [`MIX_NCHAN];             // sample word per channel
logic [`MIX_NCHAN-1:0]  odd_q;                          // low byte is next
logic [`MIX_PERIOD_W:0] per_cnt [`MIX_NCHAN];           // top bit set on underflow

always_ff @(posedge clk) begin
    for (int i = 0; i < `MIX_NCHAN; i++) begin
        if (ld.load && ld.load_chan == chan_t'(i)) begin
            buf_q[i] <= ld.load_word;
        end
    end
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        ld.buf_ok <= '0;
        odd_q     <= '0;
        for (int i = 0; i < `MIX_NCHAN; i++) begin
            per_cnt[i]  <= '0;
            sample_o[i] <= '0;
        end
    end else begin
        for (int i = 0; i < `MIX_NCHAN; i++) begin
            if (!per_cnt[i][`MIX_PERIOD_W]) begin
                per_cnt[i] <= per_cnt[i] - 1'b1;        // count down, stick at underflow
            end
            if (per_cnt[i][`MIX_PERIOD_W] && ld.buf_ok[i]) begin
                per_cnt[i]  <= {1'b0, period_i[i*`MIX_PERIOD_W +: `MIX_PERIOD_W]};
                odd_q[i]    <= ~odd_q[i];
                sample_o[i] <= odd_q[i] ? buf_q[i][7:0] : buf_q[i][15:8];
                if (odd_q[i]) begin
                    ld.buf_ok[i] <= 1'b0;               // word used up, ask for next
                end
            end
            if (ld.load && ld.load_chan == chan_t'(i)) begin
                ld.buf_ok[i] <= 1'b1;
            end
            if (!enable_i || restart_i[i]) begin
                per_cnt[i]   <= '1;                     // expire now
                ld.buf_ok[i] <= 1'b0;
                odd_q[i]     <= 1'b0;                   // start on high byte
            end
            if (!enable_i) begin
                sample_o[i] <= '0;                      // silence while off
            end
        end
    end
end

endmodule

`default_nettype wire

// File: design/sample_fetch.sv
`default_nettype none
`timescale 1ns/1ps

`include "mixer_config.svh"

module sample_fetch import mixer_pkg::*; (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire logic                   enable_i,
    input  wire logic [`MIX_NCHAN-1:0]  restart_i,
    output param_addr_t                 rd_addr_o,
    input  wire word_t                  rd_data_i,
    output logic                        wr_o,
    output param_addr_t                 wr_addr_o,
    output word_t                       wr_data_o,
    output logic [`MIX_NCHAN-1:0]       reload_o,
    output logic                        dma_vram_req_o,
    output logic                        dma_tile_req_o,
    output word_t                       dma_addr_o,
    input  wire logic                   dma_ack_i,
    input  wire word_t                  dma_word_i,
    sample_load_if.fetch                ld
);

fetch_state_t           state;
chan_t                  fetch_chan;             // channel being serviced
logic [`MIX_NCHAN-1:0]  restart_q;              // pending reloads
logic                   fetch_tile;             // request goes to tile mem
logic                   empty_found;
chan_t                  empty_chan;             // lowest empty channel
word_t                  len_dec;                // length - 1, bit 15 is underflow

function automatic param_addr_t paddr(input logic work, input chan_t ch, input logic len);
    paddr = {work, ch, len};
endfunction

assign len_dec = {1'b0, rd_data_i[`MIX_TILE_B-1:0]} - word_t'(1);

always_comb begin
    empty_found = 1'b0;
    empty_chan  = '0;
    for (int i = `MIX_NCHAN-1; i >= 0; i--) begin   // lowest index wins
        if (!ld.buf_ok[i]) begin
            empty_found = 1'b1;
            empty_chan  = chan_t'(i);
        end
    end
end

// returned word goes straight to the player, valid next cycle
assign ld.load      = (state == ST_WAIT_ACK) && dma_ack_i;
assign ld.load_chan = fetch_chan;
assign ld.load_word = dma_word_i;

always_ff @(posedge clk) begin
    if (reset_i) begin
        state          <= ST_CHECK;
        fetch_chan     <= '0;
        restart_q      <= `MIX_RESTART_RST;
        fetch_tile     <= 1'b0;
        rd_addr_o      <= '0;
        wr_o           <= 1'b0;
        wr_addr_o      <= '0;
        wr_data_o      <= '0;
        reload_o       <= '0;
        dma_vram_req_o <= 1'b0;
        dma_tile_req_o <= 1'b0;
        dma_addr_o     <= '0;
    end else begin
        wr_o      <= 1'b0;
        reload_o  <= '0;
        restart_q <= restart_q | restart_i | {`MIX_NCHAN{~enable_i}};
        case (state)
            ST_CHECK: begin
                if (empty_found) begin
                    fetch_chan <= empty_chan;
                    rd_addr_o  <= paddr(`MIX_WORK_SEL, empty_chan, `MIX_LEN_SEL);
                    state      <= ST_RD_PTR;
                end
            end
            ST_RD_PTR: begin                            // length counter on its way
                rd_addr_o <= paddr(`MIX_WORK_SEL, fetch_chan, `MIX_START_SEL);
                state     <= ST_DEC_LEN;
            end
            ST_DEC_LEN: begin
                wr_o      <= 1'b1;                      // count down, keep tile bit
                wr_addr_o <= paddr(`MIX_WORK_SEL, fetch_chan, `MIX_LEN_SEL);
                wr_data_o <= {rd_data_i[`MIX_TILE_B], len_dec[`MIX_TILE_B-1:0]};
                restart_q[fetch_chan] <= 1'b0;
                if (len_dec[`MIX_TILE_B] || restart_q[fetch_chan]
                        || restart_i[fetch_chan]) begin
                    rd_addr_o <= paddr(`MIX_HOST_SEL, fetch_chan, `MIX_LEN_SEL);
                    state     <= ST_RELOAD;
                end else begin
                    fetch_tile <= rd_data_i[`MIX_TILE_B];
                    state      <= ST_REQ;               // pointer data arrives next
                end
            end
            ST_RELOAD: begin                            // pointer data ignored
                rd_addr_o <= paddr(`MIX_HOST_SEL, fetch_chan, `MIX_START_SEL);
                state     <= ST_SET_LEN;
            end
            ST_SET_LEN: begin
                wr_o                 <= 1'b1;           // length reg into counter
                wr_addr_o            <= paddr(`MIX_WORK_SEL, fetch_chan, `MIX_LEN_SEL);
                wr_data_o            <= rd_data_i;
                fetch_tile           <= rd_data_i[`MIX_TILE_B];
                reload_o[fetch_chan] <= 1'b1;
                state                <= ST_REQ;
            end
            ST_REQ: begin                               // pointer or start on rd_data_i
                dma_vram_req_o <= ~fetch_tile;
                dma_tile_req_o <= fetch_tile;
                dma_addr_o     <= rd_data_i;
                state          <= ST_WAIT_ACK;
            end
            ST_WAIT_ACK: begin
                if (dma_ack_i) begin
                    dma_vram_req_o <= 1'b0;
                    dma_tile_req_o <= 1'b0;
                    wr_o           <= 1'b1;             // pointer write-back, off the length slot
                    wr_addr_o      <= paddr(`MIX_WORK_SEL, fetch_chan, `MIX_START_SEL);
                    wr_data_o      <= dma_addr_o + word_t'(1);
                    state          <= ST_CHECK;
                end
            end
            default: state <= ST_CHECK;
        endcase
        if (!enable_i) begin                            // abandon fetch, drop request
            state          <= ST_CHECK;
            dma_vram_req_o <= 1'b0;
            dma_tile_req_o <= 1'b0;
        end
    end
end

a_one_req: assert property (@(posedge clk) disable iff (reset_i)
    !(dma_vram_req_o && dma_tile_req_o));

endmodule

`default_nettype wire

// File: design/param_mem.sv
`default_nettype none
`timescale 1ns/1ps

`include "mixer_config.svh"

module param_mem import mixer_pkg::*; (
    input  wire logic           clk,
    input  wire param_addr_t    rd_addr_i,
    output word_t               rd_data_o,      // valid one cycle after rd_addr_i
    input  wire logic           wr_i,
    input  wire param_addr_t    wr_addr_i,
    input  wire word_t          wr_data_i
);

word_t mem [2**`MIX_PARAM_AW];                  // host regs low half, counters high half

always_ff @(posedge clk) begin
    if (wr_i) begin
        mem[wr_addr_i] <= wr_data_i;
    end
    rd_data_o <= mem[rd_addr_i];                // registered read
end

endmodule

`default_nettype wire

// File: design/param_write_arbiter.sv
`default_nettype none
`timescale 1ns/1ps

`include "mixer_config.svh"

module param_write_arbiter import mixer_pkg::*; (
    input  wire logic                       clk,
    input  wire logic                       reset_i,
    input  wire logic                       host_wr_i,
    input  wire logic [`MIX_PARAM_AW-2:0]   host_addr_i,    // {chan, len}
    input  wire word_t                      host_data_i,
    input  wire logic                       fetch_wr_i,
    input  wire param_addr_t                fetch_addr_i,
    input  wire word_t                      fetch_data_i,
    output logic                            mem_wr_o,
    output param_addr_t                     mem_addr_o,
    output word_t                           mem_data_o
);

logic                       pend_q;         // host write waiting
logic [`MIX_PARAM_AW-2:0]   pend_addr;      // held host address
word_t                      pend_data;      // held host data

always_ff @(posedge clk) begin
    if (reset_i) begin
        pend_q <= 1'b0;
    end else if (host_wr_i) begin
        pend_q <= 1'b1;                     // latch new host write
    end else if (!fetch_wr_i) begin
        pend_q <= 1'b0;                     // forwarded this cycle
    end
end

always_ff @(posedge clk) begin
    if (host_wr_i) begin
        pend_addr <= host_addr_i;
        pend_data <= host_data_i;
    end
end

// fetch engine wins, host goes on the next free cycle
always_comb begin
    mem_wr_o   = fetch_wr_i | pend_q;
    mem_addr_o = fetch_addr_i;
    mem_data_o = fetch_data_i;
    if (!fetch_wr_i) begin
        mem_addr_o = {`MIX_HOST_SEL, pend_addr};    // host half only
        mem_data_o = pend_data;
    end
end

// fetch never writes twice in a row, so a blocked write lands next cycle
a_pend_once: assert property (@(posedge clk) disable iff (reset_i)
    (pend_q && fetch_wr_i) |=> !fetch_wr_i);

endmodule

`default_nettype wire

// File: design/sample_load_if.sv
`default_nettype none
`timescale 1ns/1ps

`include "mixer_config.svh"

interface sample_load_if
    import mixer_pkg::*;
();
    logic [`MIX_NCHAN-1:0]  buf_ok;         // word buffer valid per channel
    logic                   load;           // one cycle load strobe
    chan_t                  load_chan;      // channel being loaded
    word_t                  load_word;      // two samples, high byte first

    modport fetch (output load, load_chan, load_word, input buf_ok);
    modport player (input load, load_chan, load_word, output buf_ok);
endinterface

`default_nettype wire

// File: design/mixer_pkg.sv
`default_nettype none

`include "mixer_config.svh"

package mixer_pkg;

typedef logic [`MIX_WORD_W-1:0]     word_t;         // memory, DMA or address word
typedef logic signed [7:0]          sample_t;       // one signed sample
typedef logic [`MIX_CHAN_W-1:0]     chan_t;         // channel index
typedef logic [`MIX_PARAM_AW-1:0]   param_addr_t;   // parameter memory address

typedef enum logic [2:0] {
    ST_CHECK,                                       // look for empty buffer
    ST_RD_PTR,                                      // queue pointer read
    ST_DEC_LEN,                                     // length countdown
    ST_RELOAD,                                      // queue start read
    ST_SET_LEN,                                     // copy length reg to counter
    ST_REQ,                                         // raise DMA request
    ST_WAIT_ACK                                     // wait for DMA word
} fetch_state_t;

endpackage

`default_nettype wire

// File: include/mixer_config.svh
`ifndef MIXER_CONFIG_SVH
`define MIXER_CONFIG_SVH

`define MIX_NCHAN       4           // audio channels
`define MIX_CHAN_W      2           // channel index bits
`define MIX_WORD_W      16          // param mem and DMA word
`define MIX_PARAM_AW    4           // {work, chan[1:0], len}
`define MIX_PERIOD_W    15          // sample period bits
`define MIX_VOL_W       7           // unsigned volume bits
`define MIX_DAC_W       8           // PDM DAC resolution
`define MIX_TILE_B      15          // length word bit, tile mem select

// parameter address fields
`define MIX_WORK_SEL    1'b1        // working counters half
`define MIX_HOST_SEL    1'b0        // host register half
`define MIX_LEN_SEL     1'b1        // length word
`define MIX_START_SEL   1'b0        // start/pointer word

// reset values
`define MIX_DAC_RST     8'h00       // DAC value after reset, pdm low
`define MIX_RESTART_RST 4'hF        // force reload of every channel

`endif
